// ==== rtl/phxPkg.sv ====
package phxPkg;

	// ==============================
	// Basic types
	// ==============================

	typedef logic [31:0] phxWord;
	typedef logic [5:0] phxReg;

	// Architectural stack pointer, banked copies live in r60 to r63
	localparam phxReg SP_REG = 6'd31;

	// ==============================
	// Instruction encodings
	// ==============================

	typedef enum logic [5:0] {
		OP_NOP     = 6'h00,
		OP_R2      = 6'h02,
		OP_ADDI    = 6'h04,
		OP_SUBFI   = 6'h05,
		OP_ANDI    = 6'h08,
		OP_ORI     = 6'h09,
		OP_XORI    = 6'h0A,
		OP_CMP_EQI = 6'h10,
		OP_CMP_LTI = 6'h11,
		OP_PFX     = 6'h3F
	} phxOpcode;

	// Function field of the R2 format
	typedef enum logic [5:0] {
		OP_ADD     = 6'h04,
		OP_SUB     = 6'h05,
		OP_AND     = 6'h08,
		OP_OR      = 6'h09,
		OP_XOR     = 6'h0A,
		OP_CMP_EQ  = 6'h10,
		OP_CMP_LT  = 6'h11,
		OP_CMP_LTU = 6'h12,
		OP_SLL     = 6'h18,
		OP_SRL     = 6'h19,
		OP_SRA     = 6'h1A
	} phxFunc;

	// Opcode sits in the low six bits of every format
	typedef struct packed {
		logic [25:0] payload;
		phxOpcode opcode;
	} phxAnyFmt;

	typedef struct packed {
		logic [1:0] spare;
		phxFunc func;
		phxReg Rb;
		phxReg Ra;
		phxReg Rt;
		phxOpcode opcode;
	} phxR2Fmt;

	typedef struct packed {
		logic [13:0] imm;
		phxReg Ra;
		phxReg Rt;
		phxOpcode opcode;
	} phxRiFmt;

	// Prefix supplies the upper immediate bits of the next instruction
	typedef struct packed {
		logic [25:0] imm;
		phxOpcode opcode;
	} phxPfxFmt;

	typedef union packed {
		phxAnyFmt any;
		phxR2Fmt r2;
		phxRiFmt ri;
		phxPfxFmt pfx;
	} phxInsn;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SUBF,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_EQ,
		ALU_LT,
		ALU_LTU
	} phxAluOp;

	// ==============================
	// Pipeline buses
	// ==============================

	typedef struct packed {
		phxInsn insn;
		logic [2:0] spSel;
	} phxFetch;

	// b carries the immediate for the RI format
	typedef struct packed {
		phxAluOp op;
		phxReg Rt;
		phxWord a;
		phxWord b;
		logic rfwr;
	} phxDecode;

	typedef struct packed {
		phxReg Rt;
		phxWord value;
		logic rfwr;
	} phxExec;

	typedef struct packed {
		phxReg Rt;
		phxWord value;
	} phxResult;

endpackage

// ==== rtl/phxDecoder.sv ====
`timescale 1ns/1ps

module phxDecoder (
	input  logic clk,
	input  logic rstN,
	input  logic inValid,
	output logic inReady,
	input  phxPkg::phxFetch inFetch,
	output phxPkg::phxReg raAddr,
	output phxPkg::phxReg rbAddr,
	input  phxPkg::phxWord raData,
	input  phxPkg::phxWord rbData,
	output logic decValid,
	input  logic decReady,
	output phxPkg::phxDecode dec,
	input  phxPkg::phxReg exRt,
	input  logic exWr,
	input  phxPkg::phxReg resRt,
	input  logic resWr
);
	import phxPkg::*;

	phxInsn insn;
	logic isR2;
	logic isPfx;
	logic sendDown;
	logic hasRa;
	logic hasRb;
	phxAluOp aluOp;
	phxReg rawRt;
	phxReg rawRa;
	phxReg rt;
	phxWord imm;
	logic pfxValid;
	logic [17:0] pfxImm;
	phxReg [2:0] pendRt;
	logic [2:0] pendWr;
	logic hazard;
	logic loadDec;
	logic accept;

	// Register 31 selects one of the banked stack pointers
	function automatic phxReg mapSp(input phxReg r, input logic [2:0] sel);
		if (r == SP_REG && sel >= 3'd1 && sel <= 3'd4)
			return 6'd59 + 6'(sel);
		return r;
	endfunction

	function automatic logic pending(input phxReg src, input phxReg [2:0] rts,
		input logic [2:0] wrs);
		logic hit;
		hit = 1'b0;
		for (int i = 0; i < 3; i++) begin
			if (wrs[i] && rts[i] == src)
				hit = 1'b1;
		end
		return hit && (src != '0);
	endfunction

	// ==============================
	// Instruction decode
	// ==============================

	assign insn = inFetch.insn;
	assign isR2 = insn.any.opcode == OP_R2;
	assign isPfx = insn.any.opcode == OP_PFX;

	always_comb begin
		aluOp = ALU_ADD;
		sendDown = 1'b1;
		case (insn.any.opcode)
		OP_R2:
			case (insn.r2.func)
			OP_ADD:     aluOp = ALU_ADD;
			OP_SUB:     aluOp = ALU_SUB;
			OP_AND:     aluOp = ALU_AND;
			OP_OR:      aluOp = ALU_OR;
			OP_XOR:     aluOp = ALU_XOR;
			OP_SLL:     aluOp = ALU_SLL;
			OP_SRL:     aluOp = ALU_SRL;
			OP_SRA:     aluOp = ALU_SRA;
			OP_CMP_EQ:  aluOp = ALU_EQ;
			OP_CMP_LT:  aluOp = ALU_LT;
			OP_CMP_LTU: aluOp = ALU_LTU;
			default:    sendDown = 1'b0;
			endcase
		OP_ADDI:    aluOp = ALU_ADD;
		OP_SUBFI:   aluOp = ALU_SUBF;
		OP_ANDI:    aluOp = ALU_AND;
		OP_ORI:     aluOp = ALU_OR;
		OP_XORI:    aluOp = ALU_XOR;
		OP_CMP_EQI: aluOp = ALU_EQ;
		OP_CMP_LTI: aluOp = ALU_LT;
		// NOP, PFX and unknown codes send nothing on
		default:    sendDown = 1'b0;
		endcase
	end

	// Every operation sent on reads Ra, only R2 reads Rb
	assign hasRa = sendDown;
	assign hasRb = sendDown & isR2;

	// Rt and Ra sit at the same bits in the R2 and RI formats
	assign rawRt = insn.ri.Rt;
	assign rawRa = insn.ri.Ra;
	assign rt = mapSp(rawRt, inFetch.spSel);
	assign raAddr = hasRa ? mapSp(rawRa, inFetch.spSel) : '0;
	assign rbAddr = hasRb ? mapSp(insn.r2.Rb, inFetch.spSel) : '0;

	// Sign extended immediate, widened by a preceding prefix
	always_comb begin
		imm = {{18{insn.ri.imm[13]}}, insn.ri.imm};
		if (pfxValid)
			imm[31:14] = pfxImm;
	end

	// ==============================
	// Interlock and handshake
	// ==============================

	// Writes still on their way to the register file
	assign pendRt = {resRt, exRt, dec.Rt};
	assign pendWr = {resWr, exWr, decValid & dec.rfwr};

	assign hazard = pending(raAddr, pendRt, pendWr) | pending(rbAddr, pendRt, pendWr);
	assign loadDec = ~decValid | decReady;
	assign inReady = loadDec & ~hazard;
	assign accept = inValid & inReady;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			decValid <= 1'b0;
			pfxValid <= 1'b0;
		end else begin
			if (loadDec)
				decValid <= accept & sendDown;
			// Prefix applies only to the very next accepted instruction
			if (accept)
				pfxValid <= isPfx;
		end
	end

	always_ff @(posedge clk) begin
		if (accept && isPfx)
			pfxImm <= insn.pfx.imm[17:0];
		if (accept && sendDown) begin
			dec.op <= aluOp;
			dec.Rt <= rt;
			dec.a <= raData;
			dec.b <= isR2 ? rbData : imm;
			dec.rfwr <= rt != '0;
		end
	end

endmodule

// ==== rtl/phxRegFile.sv ====
`timescale 1ns/1ps

module phxRegFile (
	input  logic clk,
	input  logic rstN,
	input  phxPkg::phxReg raAddr,
	input  phxPkg::phxReg rbAddr,
	output phxPkg::phxWord raData,
	output phxPkg::phxWord rbData,
	input  logic wrEn,
	input  phxPkg::phxReg wrAddr,
	input  phxPkg::phxWord wrData
);
	import phxPkg::*;

	// Includes the banked stack pointers in r60 to r63
	phxWord regs [64];

	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < 64; i++)
				regs[i] <= '0;
		end else if (wrEn) begin
			regs[wrAddr] <= wrData;
		end
	end

	// r0 always reads as zero
	assign raData = (raAddr == '0) ? '0 : regs[raAddr];
	assign rbData = (rbAddr == '0) ? '0 : regs[rbAddr];

endmodule

// ==== rtl/phxAlu.sv ====
`timescale 1ns/1ps

module phxAlu (
	input  logic clk,
	input  logic rstN,
	input  logic decValid,
	output logic decReady,
	input  phxPkg::phxDecode dec,
	output logic exValid,
	input  logic exReady,
	output phxPkg::phxExec ex,
	output phxPkg::phxReg exRt,
	output logic exWr
);
	import phxPkg::*;

	phxWord aluOut;
	logic [4:0] shamt;

	assign shamt = dec.b[4:0];

	// ==============================
	// Integer ALU
	// ==============================

	always_comb begin
		case (dec.op)
		ALU_ADD:  aluOut = dec.a + dec.b;
		ALU_SUB:  aluOut = dec.a - dec.b;
		// Subtract from, used by SUBFI
		ALU_SUBF: aluOut = dec.b - dec.a;
		ALU_AND:  aluOut = dec.a & dec.b;
		ALU_OR:   aluOut = dec.a | dec.b;
		ALU_XOR:  aluOut = dec.a ^ dec.b;
		ALU_SLL:  aluOut = dec.a << shamt;
		ALU_SRL:  aluOut = dec.a >> shamt;
		ALU_SRA:  aluOut = phxWord'($signed(dec.a) >>> shamt);
		ALU_EQ:   aluOut = {31'd0, dec.a == dec.b};
		ALU_LT:   aluOut = {31'd0, $signed(dec.a) < $signed(dec.b)};
		ALU_LTU:  aluOut = {31'd0, dec.a < dec.b};
		default:  aluOut = '0;
		endcase
	end

	// ==============================
	// Pipeline register
	// ==============================

	assign decReady = ~exValid | exReady;

	always_ff @(posedge clk) begin
		if (!rstN)
			exValid <= 1'b0;
		else if (decReady)
			exValid <= decValid;
	end

	always_ff @(posedge clk) begin
		if (decValid && decReady) begin
			ex.Rt <= dec.Rt;
			ex.value <= aluOut;
			ex.rfwr <= dec.rfwr;
		end
	end

	// Pending write seen by the decoder interlock
	assign exRt = ex.Rt;
	assign exWr = exValid & ex.rfwr;

endmodule

// ==== rtl/phxResult.sv ====
`timescale 1ns/1ps

module phxResult (
	input  logic clk,
	input  logic rstN,
	input  logic exValid,
	output logic exReady,
	input  phxPkg::phxExec ex,
	output logic wrEn,
	output phxPkg::phxReg wrAddr,
	output phxPkg::phxWord wrData,
	output phxPkg::phxReg resRt,
	output logic resWr,
	output logic resValid,
	input  logic resReady,
	output phxPkg::phxResult result
);

	logic take;
	logic resRfwr;

	assign exReady = ~resValid | resReady;
	assign take = exValid & exReady;

	// Register file is written on the same edge the entry is taken
	assign wrEn = take & ex.rfwr;
	assign wrAddr = ex.Rt;
	assign wrData = ex.value;

	always_ff @(posedge clk) begin
		if (!rstN)
			resValid <= 1'b0;
		else if (exReady)
			resValid <= exValid;
	end

	// Output held stable until the consumer takes it
	always_ff @(posedge clk) begin
		if (take) begin
			result.Rt <= ex.Rt;
			result.value <= ex.value;
			resRfwr <= ex.rfwr;
		end
	end

	assign resRt = result.Rt;
	assign resWr = resValid & resRfwr;

endmodule

// ==== rtl/phxCore.sv ====
`timescale 1ns/1ps

module phxCore (
	input  logic clk,
	input  logic rstN,
	input  logic inValid,
	output logic inReady,
	input  phxPkg::phxFetch inFetch,
	output logic resValid,
	input  logic resReady,
	output phxPkg::phxResult result
);
	import phxPkg::*;

	phxReg raAddr;
	phxReg rbAddr;
	phxWord raData;
	phxWord rbData;
	logic decValid;
	logic decReady;
	phxDecode dec;
	logic exValid;
	logic exReady;
	phxExec ex;
	phxReg exRt;
	logic exWr;
	phxReg resRt;
	logic resWr;
	logic wrEn;
	phxReg wrAddr;
	phxWord wrData;

	// Decode stage and operand read
	phxDecoder uDecoder (
		.clk(clk),
		.rstN(rstN),
		.inValid(inValid),
		.inReady(inReady),
		.inFetch(inFetch),
		.raAddr(raAddr),
		.rbAddr(rbAddr),
		.raData(raData),
		.rbData(rbData),
		.decValid(decValid),
		.decReady(decReady),
		.dec(dec),
		.exRt(exRt),
		.exWr(exWr),
		.resRt(resRt),
		.resWr(resWr)
	);

	phxRegFile uRegFile (
		.clk(clk),
		.rstN(rstN),
		.raAddr(raAddr),
		.rbAddr(rbAddr),
		.raData(raData),
		.rbData(rbData),
		.wrEn(wrEn),
		.wrAddr(wrAddr),
		.wrData(wrData)
	);

	phxAlu uAlu (
		.clk(clk),
		.rstN(rstN),
		.decValid(decValid),
		.decReady(decReady),
		.dec(dec),
		.exValid(exValid),
		.exReady(exReady),
		.ex(ex),
		.exRt(exRt),
		.exWr(exWr)
	);

	// Writeback and output handshake
	phxResult uResult (
		.clk(clk),
		.rstN(rstN),
		.exValid(exValid),
		.exReady(exReady),
		.ex(ex),
		.wrEn(wrEn),
		.wrAddr(wrAddr),
		.wrData(wrData),
		.resRt(resRt),
		.resWr(resWr),
		.resValid(resValid),
		.resReady(resReady),
		.result(result)
	);

endmodule

// ==== bench/phxClockGen.sv ====
`timescale 1ns/1ps

module phxClockGen (
	output logic clk,
	output logic rstN
);

	// 100 ns period
	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Reset low over the first four rising edges
	initial begin
		rstN = 1'b0;
		repeat (4) @(posedge clk);
		rstN <= 1'b1;
	end

endmodule

// ==== bench/phxTb.sv ====
`timescale 1ns/1ps

module phxTb;
	import phxPkg::*;

	localparam int MEM_WORDS = 256;
	localparam int CYCLES_PER_ENTRY = 20;
	localparam string STIM_PATH = "bench/phxStim.txt";

	logic clk;
	logic rstN;
	logic inValid;
	logic inReady;
	phxFetch inFetch;
	logic resValid;
	logic resReady;
	phxResult result;

	// Word 0 and 1 hold the counts, then instruction pairs, then expected pairs
	logic [31:0] stim [MEM_WORDS];
	int numInsn;
	int numExp;
	logic [31:0] lcgState = 32'ha00e_15cc;

	phxClockGen uClockGen (
		.clk(clk),
		.rstN(rstN)
	);

	phxCore dut (
		.clk(clk),
		.rstN(rstN),
		.inValid(inValid),
		.inReady(inReady),
		.inFetch(inFetch),
		.resValid(resValid),
		.resReady(resReady),
		.result(result)
	);

	// ==============================
	// Helpers
	// ==============================

	function automatic logic [31:0] nextRand();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	function automatic phxFetch fetchAt(input int idx);
		phxFetch f;
		f.insn = stim[2 + 2 * idx];
		f.spSel = stim[3 + 2 * idx][2:0];
		return f;
	endfunction

	task automatic checkValue(input string name, input phxWord got, input phxWord exp);
		if (got !== exp) begin
			$display("[ERROR] %0d ns %s got %h expected %h", $time, name, got, exp);
			$display("Test failed");
			$fatal(1, "wrong value on %s", name);
		end
	endtask

	task automatic checkTarget(input string name, input phxReg got, input phxReg exp);
		if (got !== exp) begin
			$display("[ERROR] %0d ns %s got %0d expected %0d", $time, name, got, exp);
			$display("Test failed");
			$fatal(1, "wrong target on %s", name);
		end
	endtask

	// ==============================
	// Stimulus
	// ==============================

	initial begin : driveInputs
		int insnIdx;
		logic fire;
		logic [31:0] r;
		inValid = 1'b0;
		inFetch = '0;
		resReady = 1'b0;
		insnIdx = 0;
		$readmemh(STIM_PATH, stim);
		numInsn = stim[0];
		numExp = stim[1];
		if (numInsn <= 0 || numExp <= 0 || 2 + 2 * (numInsn + numExp) > MEM_WORDS
			|| $isunknown(stim[1 + 2 * (numInsn + numExp)])) begin
			$display("Stimulus file %s is missing or incomplete", STIM_PATH);
			$display("Test failed");
			$fatal(1, "no usable stimulus");
		end
		wait (rstN === 1'b1);
		forever begin
			// Handshake is judged mid cycle where both sides are settled
			@(negedge clk);
			fire = inValid && inReady;
			@(posedge clk);
			if (fire)
				insnIdx++;
			if (!inValid || fire) begin
				r = nextRand();
				// Roughly one idle cycle in four
				if (insnIdx < numInsn && r[31:30] != 2'b00) begin
					inValid <= 1'b1;
					inFetch <= fetchAt(insnIdx);
				end else begin
					inValid <= 1'b0;
				end
			end
			r = nextRand();
			resReady <= r[31:30] != 2'b00;
		end
	end

	// ==============================
	// Result checking
	// ==============================

	initial begin : checkResults
		int expIdx;
		int base;
		expIdx = 0;
		wait (rstN === 1'b1);
		base = 2 + 2 * numInsn;
		while (expIdx < numExp) begin
			@(negedge clk);
			if (resValid && resReady) begin
				checkTarget("result.Rt", result.Rt, stim[base + 2 * expIdx][5:0]);
				checkValue("result.value", result.value, stim[base + 2 * expIdx + 1]);
				expIdx++;
			end
		end
		$display("Test passed");
		$finish;
	end

	// Generous budget per stim entry
	initial begin : watchdog
		int limit;
		wait (rstN === 1'b1);
		limit = (numInsn + numExp) * CYCLES_PER_ENTRY;
		repeat (limit) @(posedge clk);
		$display("Timeout, results still missing after %0d cycles", limit);
		$display("Test failed");
		$fatal(1, "watchdog expired");
	end

endmodule

// ==== bench/phxStim.txt ====
// Counts in hex: instructions, expected results
// Instruction lines: word spSel; expected lines: Rt value
1C 1A
01900044 0 // addi r1, r0, 100
FFF40084 0 // addi r2, r0, -3
040810C2 0 // add r3, r1, r2
05081102 0 // sub r4, r1, r2
00281145 0 // subfi r5, r1, 10
03C02188 0 // andi r6, r2, 0xf0
800C11C9 0 // ori r7, r1, 0x2003
03FC620A 0 // xori r8, r6, 0xff
18201242 0 // sll r9, r1, r8
19202282 0 // srl r10, r2, r8
1A2022C2 0 // sra r11, r2, r8
10041302 0 // cmp.eq r12, r1, r1
11042342 0 // cmp.lt r13, r2, r1
12042382 0 // cmp.ltu r14, r2, r1
018433D0 0 // cmp.eqi r15, r3, 97
FFFC1411 0 // cmp.lti r16, r1, -1
0048D17F 0 // pfx 0x12345
59E00444 0 // addi r17, r0, 0x1678
00000000 0 // nop
59E00484 0 // addi r18, r0, 0x1678
044407C4 1 // addi sp, r0, 0x111
111007C4 4 // addi sp, r0, 0x444
00C407C4 0 // addi r31, r0, 0x31
0005F4C4 1 // addi r19, sp, 1
0405F7C2 4 // add sp, sp, r1
0001F504 5 // addi r20, r31, 0
00141004 0 // addi r0, r1, 5
04040542 0 // add r21, r0, r1
01 00000064
02 FFFFFFFD
03 00000061
04 00000067
05 FFFFFFA6
06 000000F0
07 FFFFE067
08 0000000F
09 00320000
0A 0001FFFF
0B FFFFFFFF
0C 00000001
0D 00000001
0E 00000000
0F 00000001
10 00000000
11 48D15678
12 00001678
3C 00000111
3F 00000444
1F 00000031
13 00000112
3F 000004A8
14 00000031
00 00000069
15 00000064

// ==== sim.f ====
rtl/phxPkg.sv
rtl/phxDecoder.sv
rtl/phxRegFile.sv
rtl/phxAlu.sv
rtl/phxResult.sv
rtl/phxCore.sv
bench/phxClockGen.sv
bench/phxTb.sv

// ==== Bender.yml ====
package:
  name: phx_core

sources:
  - rtl/phxPkg.sv
  - rtl/phxDecoder.sv
  - rtl/phxRegFile.sv
  - rtl/phxAlu.sv
  - rtl/phxResult.sv
  - rtl/phxCore.sv
  - target: simulation
    files:
      - bench/phxClockGen.sv
      - bench/phxTb.sv
